// ==== design/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // ========================================================================
    // Widths and sizes
    // ========================================================================

    // Datapath width
    localparam int xlen = 32;
    // Shift amount taken from the low bits of op_b
    localparam int shamt_bits = $clog2(xlen);
    // Execution lanes fed by the reservation stations
    localparam int num_lanes = 3;
    localparam int lane_sel_bits = $clog2(num_lanes);
    // Physical register tag
    localparam int phys_reg_bits = 6;

    // Result queue per lane, also the issue credits granted after reset
    localparam int lane_queue_depth = 4;
    localparam int lane_queue_ptr_bits = $clog2(lane_queue_depth);
    localparam int lane_queue_cnt_bits = $clog2(lane_queue_depth + 1);

    // CDB slots granted by the consumer after reset
    localparam int cdb_credits = 2;
    localparam int cdb_credit_bits = $clog2(cdb_credits + 1);

    // ========================================================================
    // Encodings
    // ========================================================================

    // ALU operation select
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // Control-flow kind, none for plain ALU work
    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_beq  = 4'd1,
        br_bne  = 4'd2,
        br_blt  = 4'd3,
        br_bge  = 4'd4,
        br_bltu = 4'd5,
        br_bgeu = 4'd6,
        br_jal  = 4'd7,
        br_jalr = 4'd8
    } branch_sel_e;

    // ========================================================================
    // Bundles
    // ========================================================================

    // One issued instruction from a reservation station
    typedef struct packed {
        logic [phys_reg_bits-1:0] phys_rd;
        logic [xlen-1:0]          pc;
        logic [xlen-1:0]          op_a;
        logic [xlen-1:0]          op_b;
        alu_op_e                  alu_op;
        branch_sel_e              branch_sel;
        logic                     pred_taken;
        logic [xlen-1:0]          pred_target;
        // pc + imm, formed at decode
        logic [xlen-1:0]          branch_target;
    } exec_req_t;

    // One CDB broadcast
    typedef struct packed {
        logic [phys_reg_bits-1:0] phys_rd;
        logic [xlen-1:0]          result;
    } cdb_t;

    // Resolved branch or jalr, sent to the predictor and the ROB
    typedef struct packed {
        logic            valid;
        logic            is_jalr;
        logic            taken;
        logic            mispredict;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] correct_pc;
        logic [xlen-1:0] target;
    } branch_update_t;

endpackage

`default_nettype wire

// ==== design/alu_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_shifter
    import exec_pkg::*;
(
    input  logic [xlen-1:0] op_a,
    input  logic [xlen-1:0] op_b,
    input  alu_op_e         alu_op,
    output logic [xlen-1:0] result,
    output logic            zero,
    output logic            negative,
    output logic            carry,
    output logic            overflow
);

    // Subtraction path with carry out, a + ~b + 1
    logic [xlen:0]           diff_ext;
    logic [xlen-1:0]         diff;
    logic [shamt_bits-1:0]   shamt;

    assign diff_ext = {1'b0, op_a} + {1'b0, ~op_b} + {{xlen{1'b0}}, 1'b1};
    assign diff     = diff_ext[xlen-1:0];
    assign shamt    = op_b[shamt_bits-1:0];

    // Flags always follow a - b, so branch compares see them regardless of op
    assign zero     = (diff == '0);
    assign negative = diff[xlen-1];
    // Carry set means no borrow, i.e. a >= b unsigned
    assign carry    = diff_ext[xlen];
    // Signed overflow when operand signs differ and the sign of a flips
    assign overflow = (op_a[xlen-1] != op_b[xlen-1]) && (diff[xlen-1] != op_a[xlen-1]);

    always_comb begin
        case (alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = diff;
            alu_and:    result = op_a & op_b;
            alu_or:     result = op_a | op_b;
            alu_xor:    result = op_a ^ op_b;
            alu_sll:    result = op_a << shamt;
            alu_srl:    result = op_a >> shamt;
            // Arithmetic shift keeps the sign bit
            alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
            // Signed less than from N xor V
            alu_slt:    result = {{(xlen-1){1'b0}}, negative ^ overflow};
            // Unsigned less than is a borrow
            alu_sltu:   result = {{(xlen-1){1'b0}}, ~carry};
            // lui style moves
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/branch_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolver
    import exec_pkg::*;
(
    input  exec_req_t       req,
    input  logic [xlen-1:0] alu_result,
    input  logic            zero,
    input  logic            negative,
    input  logic            carry,
    input  logic            overflow,
    output branch_update_t  update,
    output logic [xlen-1:0] link_result
);

    logic            taken;
    logic            is_jalr;
    logic            is_jump;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] jalr_target;

    assign pc_plus4    = req.pc + xlen'(4);
    // jalr target is rs1 + imm with bit 0 forced low
    assign jalr_target = {alu_result[xlen-1:1], 1'b0};
    assign is_jalr     = (req.branch_sel == br_jalr);
    assign is_jump     = is_jalr || (req.branch_sel == br_jal);

    // Condition evaluation from the subtract flags
    always_comb begin
        case (req.branch_sel)
            br_beq:          taken = zero;
            br_bne:          taken = ~zero;
            br_blt:          taken = negative ^ overflow;
            br_bge:          taken = ~(negative ^ overflow);
            br_bltu:         taken = ~carry;
            br_bgeu:         taken = carry;
            br_jal, br_jalr: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        // jal is fully resolved at fetch, so only branches and jalr report
        update.valid   = (req.branch_sel != br_none) && (req.branch_sel != br_jal);
        update.is_jalr = is_jalr;
        update.taken   = taken;
        update.pc      = req.pc;
        if (is_jalr) begin
            update.target     = jalr_target;
            update.correct_pc = jalr_target;
            // Wrong target from the BTB
            update.mispredict = (jalr_target != req.pred_target);
        end else begin
            update.target     = req.branch_target;
            update.correct_pc = taken ? req.branch_target : pc_plus4;
            // Direction mismatch
            update.mispredict = update.valid && (taken != req.pred_taken);
        end
    end

    // Jumps write the return address to rd
    assign link_result = is_jump ? pc_plus4 : alu_result;

endmodule

`default_nettype wire

// ==== design/execute_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_lane
    import exec_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           issue_valid,
    input  exec_req_t      issue_req,
    output logic           issue_credit,
    output branch_update_t branch_update,
    output logic           queue_valid,
    output cdb_t           queue_head,
    input  logic           pop
);

    // Stage 1 request
    logic           s1_valid;
    exec_req_t      s1_req;

    // Combinational execute on stage 1
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] link_result;
    logic            flag_zero;
    logic            flag_negative;
    logic            flag_carry;
    logic            flag_overflow;
    branch_update_t  res_update;

    // Stage 2 result and update
    logic            s2_valid;
    cdb_t            s2_result;
    logic            s2_update_valid;
    branch_update_t  s2_update;

    // Result queue
    cdb_t                         queue_mem [lane_queue_depth];
    logic [lane_queue_ptr_bits-1:0] wr_ptr;
    logic [lane_queue_ptr_bits-1:0] rd_ptr;
    logic [lane_queue_cnt_bits-1:0] count;
    logic                           do_pop;

    // ========================================================================
    // Stage 1
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            s1_req <= issue_req;
        end
    end

    alu_shifter u_alu (
        .op_a     (s1_req.op_a),
        .op_b     (s1_req.op_b),
        .alu_op   (s1_req.alu_op),
        .result   (alu_result),
        .zero     (flag_zero),
        .negative (flag_negative),
        .carry    (flag_carry),
        .overflow (flag_overflow)
    );

    branch_resolver u_resolver (
        .req         (s1_req),
        .alu_result  (alu_result),
        .zero        (flag_zero),
        .negative    (flag_negative),
        .carry       (flag_carry),
        .overflow    (flag_overflow),
        .update      (res_update),
        .link_result (link_result)
    );

    // ========================================================================
    // Stage 2
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid        <= 1'b0;
            s2_update_valid <= 1'b0;
        end else begin
            s2_valid        <= s1_valid;
            s2_update_valid <= s1_valid && res_update.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_result.phys_rd <= s1_req.phys_rd;
            s2_result.result  <= link_result;
            s2_update         <= res_update;
        end
    end

    // Update payload with the qualified valid bit
    always_comb begin
        branch_update       = s2_update;
        branch_update.valid = s2_update_valid;
    end

    // ========================================================================
    // Result queue
    // ========================================================================

    // Credits bound occupancy, so a write never finds the queue full
    assign do_pop      = pop && (count != '0);
    assign queue_valid = (count != '0);
    assign queue_head  = queue_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            queue_mem[wr_ptr] <= s2_result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            issue_credit <= 1'b0;
        end else begin
            if (s2_valid) begin
                wr_ptr <= (wr_ptr == lane_queue_ptr_bits'(lane_queue_depth - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == lane_queue_ptr_bits'(lane_queue_depth - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            // Occupancy moves only on a lone push or a lone pop
            if (s2_valid && !do_pop) begin
                count <= count + 1'b1;
            end else if (!s2_valid && do_pop) begin
                count <= count - 1'b1;
            end
            // One credit back to the issuer per entry drained
            issue_credit <= do_pop;
        end
    end

endmodule

`default_nettype wire

// ==== design/cdb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter
    import exec_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [num_lanes-1:0] queue_valid,
    input  cdb_t [num_lanes-1:0] queue_head,
    output logic [num_lanes-1:0] pop,
    input  logic                 cdb_credit,
    output logic                 cdb_valid,
    output cdb_t                 cdb
);

    logic [lane_sel_bits-1:0]   last_winner;
    logic [lane_sel_bits-1:0]   winner;
    logic                       found;
    logic                       grant;
    logic [cdb_credit_bits-1:0] credit_count;

    // ========================================================================
    // Round-robin pick
    // ========================================================================

    // Search starts one past the previous winner and wraps
    always_comb begin
        int idx;
        winner = last_winner;
        found  = 1'b0;
        for (int k = 1; k <= num_lanes; k++) begin
            idx = int'(last_winner) + k;
            if (idx >= num_lanes) begin
                idx = idx - num_lanes;
            end
            if (!found && queue_valid[idx]) begin
                found  = 1'b1;
                winner = lane_sel_bits'(idx);
            end
        end
    end

    // No broadcast without a consumer slot
    assign grant = found && (credit_count != '0);

    always_comb begin
        pop = '0;
        if (grant) begin
            pop[winner] = 1'b1;
        end
    end

    // ========================================================================
    // CDB register and credits
    // ========================================================================

    always_ff @(posedge clk) begin
        if (grant) begin
            cdb <= queue_head[winner];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Lane 0 gets the first turn
            last_winner  <= lane_sel_bits'(num_lanes - 1);
            cdb_valid    <= 1'b0;
            credit_count <= cdb_credit_bits'(cdb_credits);
        end else begin
            cdb_valid <= grant;
            if (grant) begin
                last_winner <= winner;
            end
            // Spend and return in one cycle cancel out
            if (grant && !cdb_credit) begin
                credit_count <= credit_count - 1'b1;
            end else if (!grant && cdb_credit) begin
                credit_count <= credit_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/superscalar_execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module superscalar_execute_stage
    import exec_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [num_lanes-1:0]           issue_valid,
    input  exec_req_t [num_lanes-1:0]      issue_req,
    output logic [num_lanes-1:0]           issue_credit,
    output branch_update_t [num_lanes-1:0] branch_update,
    input  logic                           cdb_credit,
    output logic                           cdb_valid,
    output cdb_t                           cdb
);

    // Lane queue heads toward the arbiter
    logic [num_lanes-1:0] queue_valid;
    cdb_t [num_lanes-1:0] queue_head;
    logic [num_lanes-1:0] pop;

    // Identical ALU/branch lanes
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        execute_lane u_lane (
            .clk           (clk),
            .rst_n         (rst_n),
            .issue_valid   (issue_valid[i]),
            .issue_req     (issue_req[i]),
            .issue_credit  (issue_credit[i]),
            .branch_update (branch_update[i]),
            .queue_valid   (queue_valid[i]),
            .queue_head    (queue_head[i]),
            .pop           (pop[i])
        );
    end

    // One broadcast per cycle
    cdb_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .queue_valid (queue_valid),
        .queue_head  (queue_head),
        .pop         (pop),
        .cdb_credit  (cdb_credit),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_exec_tasks.svh ====
// ============================================================================
// Directed tests
// ============================================================================

// Outputs must stay quiet until the first issue
task automatic outputs_quiet(input string phase);
    logic upd_any;
    upd_any = 1'b0;
    for (int i = 0; i < num_lanes; i++) begin
        if (branch_update[i].valid !== 1'b0) begin
            upd_any = 1'b1;
        end
    end
    if (cdb_valid !== 1'b0 || issue_credit !== '0 || upd_any) begin
        errors++;
        $display("DUT outputs active %s before any issue", phase);
    end
endtask

// Three edges in reset, then three idle edges
task automatic check_reset();
    cur_test = "reset";
    for (int n = 0; n < 6; n++) begin
        @(negedge clk);
        if (n < 3) begin
            outputs_quiet("during reset");
        end else begin
            outputs_quiet("after reset");
        end
        if (n == 2) begin
            rst_n = 1'b1;
        end
    end
endtask

task automatic alu_op_sweep();
    logic [xlen-1:0] ra;
    logic [xlen-1:0] rb;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    cur_test  = "alu_ops";
    cdb_delay = 2;
    for (int k = 0; k <= int'(alu_pass_b); k++) begin
        for (int s = 0; s < 7; s++) begin
            // Same operand class on every lane, fresh random values per lane
            for (int l = 0; l < num_lanes; l++) begin
                ra = $urandom;
                rb = $urandom;
                case (s)
                    0: {a, b} = {ra, 32'h0};
                    1: {a, b} = {ra, rb | 32'h1f};
                    2: {a, b} = {32'h8000_0000, 32'h7fff_ffff};
                    3: {a, b} = {32'h7fff_ffff, 32'h8000_0000};
                    4: {a, b} = {32'h8000_0000, 32'hffff_ffff};
                    5: {a, b} = {ra, rb};
                    default: {a, b} = {ra, ra};
                endcase
                issue_on(l, alu_op_e'(k), br_none, a, b, ra & ~32'h3, 1'b0, 32'h0, 32'h0);
            end
            next_cycle();
        end
    end
    wait_drain();
endtask

task automatic branch_sweep();
    logic [xlen-1:0] a_set [5];
    logic [xlen-1:0] b_set [5];
    logic [xlen-1:0] pc;
    int              lane;
    cur_test  = "branches";
    cdb_delay = 0;
    lane      = 0;
    // Equal, signed and unsigned orders that disagree, so each kind goes both ways
    a_set = '{32'd5, 32'd5, 32'd7, 32'hffff_fff0, 32'd3};
    b_set = '{32'd5, 32'd7, 32'd5, 32'd3, 32'hffff_fff0};
    for (int p = 0; p < 2; p++) begin
        for (int k = int'(br_beq); k <= int'(br_bgeu); k++) begin
            for (int s = 0; s < 5; s++) begin
                pc = $urandom & ~32'h3;
                issue_on(lane, alu_sub, branch_sel_e'(k), a_set[s], b_set[s], pc,
                         p[0], 32'h0, pc + ($urandom & 32'hffc));
                lane = (lane + 1) % num_lanes;
                if (lane == 0) begin
                    next_cycle();
                end
            end
        end
    end
    next_cycle();
    wait_drain();
endtask

task automatic jump_links();
    logic [xlen-1:0] pc;
    logic [xlen-1:0] ra;
    logic [xlen-1:0] rb;
    logic [xlen-1:0] tgt;
    cur_test  = "jumps";
    cdb_delay = 1;
    for (int n = 0; n < 6; n++) begin
        pc  = $urandom & ~32'h3;
        ra  = $urandom;
        rb  = $urandom;
        tgt = (ra + rb) & ~32'h1;
        // jal on lanes 0 and 2, jalr on lane 1 with a right or wrong BTB target
        issue_on(0, alu_add, br_jal, pc, 32'h100, pc, 1'b1, pc + 32'h100, pc + 32'h100);
        issue_on(1, alu_add, br_jalr, ra, rb, pc, 1'b1, n[0] ? tgt : tgt ^ 32'h40, 32'h0);
        issue_on(2, alu_add, br_jal, pc, 32'h8, pc, 1'b1, pc + 32'h8, pc + 32'h8);
        next_cycle();
    end
    wait_drain();
endtask

task automatic stall_and_drain();
    int start;
    int returned;
    cur_test     = "back_pressure";
    hold_credits = 1'b1;
    start        = broadcasts;
    for (int n = 0; n < lane_queue_depth; n++) begin
        for (int l = 0; l < num_lanes; l++) begin
            issue_on(l, alu_xor, br_none, $urandom, $urandom, 32'h0, 1'b0, 32'h0, 32'h0);
        end
        next_cycle();
    end
    // Long enough for every lane to fill its queue
    repeat (4 * lane_queue_depth) next_cycle();
    returned = credits[0] + credits[1] + credits[2];
    if (broadcasts - start > cdb_credits) begin
        errors++;
        $display("%0d broadcasts with only %0d CDB credits", broadcasts - start, cdb_credits);
    end
    if (returned != broadcasts - start) begin
        errors++;
        $display("Lanes returned %0d issue credits for %0d results sent",
                 returned, broadcasts - start);
    end
    hold_credits = 1'b0;
    wait_drain();
    for (int i = 0; i < num_lanes; i++) begin
        if (credits[i] != lane_queue_depth) begin
            errors++;
            $display("Lane %0d ended with %0d issue credits", i, credits[i]);
        end
    end
endtask

// ==== testbench/tb_execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage
    import exec_pkg::*;
;

    logic                           clk;
    logic                           rst_n;
    logic [num_lanes-1:0]           issue_valid;
    exec_req_t [num_lanes-1:0]      issue_req;
    logic [num_lanes-1:0]           issue_credit;
    branch_update_t [num_lanes-1:0] branch_update;
    logic                           cdb_credit;
    logic                           cdb_valid;
    cdb_t                           cdb;

    // Run bookkeeping
    string cur_test;
    int    errors;
    int    issued;
    int    broadcasts;
    int    outstanding;
    int    cycle;
    // About 320 results at 0.3 or more per cycle leave a wide margin
    int    cycle_limit = 4000;

    // Issue credits held per lane
    int credits [num_lanes];

    // Scoreboard indexed by tag
    logic [xlen-1:0]          exp_result [2**phys_reg_bits];
    logic                     pending    [2**phys_reg_bits];
    int                       tag_lane   [2**phys_reg_bits];
    logic [phys_reg_bits-1:0] next_tag;
    logic [phys_reg_bits-1:0] order_q [num_lanes][$];

    // Expected branch updates and the cycle each is due
    branch_update_t upd_q [num_lanes][$];
    int             due_q [num_lanes][$];

    // CDB credit returns that are delayed per test or held back
    int   ret_q [$];
    int   cdb_delay;
    logic hold_credits;

    superscalar_execute_stage dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .issue_req     (issue_req),
        .issue_credit  (issue_credit),
        .branch_update (branch_update),
        .cdb_credit    (cdb_credit),
        .cdb_valid     (cdb_valid),
        .cdb           (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================================================
    // Reference model
    // ========================================================================

    function automatic logic [xlen-1:0] expected_alu(input alu_op_e op,
                                                    input logic [xlen-1:0] a,
                                                    input logic [xlen-1:0] b);
        case (op)
            alu_add:    return a + b;
            alu_sub:    return a - b;
            alu_and:    return a & b;
            alu_or:     return a | b;
            alu_xor:    return a ^ b;
            alu_sll:    return a << b[4:0];
            alu_srl:    return a >> b[4:0];
            // Sign fill by shifting the complement
            alu_sra:    return a[xlen-1] ? ~(~a >> b[4:0]) : a >> b[4:0];
            alu_slt:    return {31'b0, $signed(a) < $signed(b)};
            alu_sltu:   return {31'b0, a < b};
            alu_pass_b: return b;
            default:    return '0;
        endcase
    endfunction

    // Branch direction straight from operand compares
    function automatic logic branch_taken(input branch_sel_e sel,
                                          input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
        case (sel)
            br_beq:          return a == b;
            br_bne:          return a != b;
            br_blt:          return $signed(a) < $signed(b);
            br_bge:          return $signed(a) >= $signed(b);
            br_bltu:         return a < b;
            br_bgeu:         return a >= b;
            br_jal, br_jalr: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    // ========================================================================
    // Driving helpers
    // ========================================================================

    task automatic next_cycle();
        @(negedge clk);
        issue_valid = '0;
    endtask

    // Drives one request on a lane for the coming edge and records the expectations
    task automatic issue_on(input int lane, input alu_op_e op, input branch_sel_e sel,
                            input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                            input logic [xlen-1:0] pc, input logic pt,
                            input logic [xlen-1:0] ptgt, input logic [xlen-1:0] btgt);
        exec_req_t       req;
        branch_update_t  upd;
        logic            taken;
        logic [xlen-1:0] jump_tgt;
        while (credits[lane] == 0) begin
            next_cycle();
        end
        req.phys_rd       = next_tag;
        req.pc            = pc;
        req.op_a          = a;
        req.op_b          = b;
        req.alu_op        = op;
        req.branch_sel    = sel;
        req.pred_taken    = pt;
        req.pred_target   = ptgt;
        req.branch_target = btgt;
        issue_req[lane]   = req;
        issue_valid[lane] = 1'b1;
        credits[lane]--;
        if (pending[next_tag]) begin
            errors++;
            $display("Tag %0d reissued in %s while still in flight", next_tag, cur_test);
        end
        pending[next_tag]  = 1'b1;
        tag_lane[next_tag] = lane;
        order_q[lane].push_back(next_tag);
        outstanding++;
        issued++;
        taken = branch_taken(sel, a, b);
        // Jumps write the return address
        if (sel == br_jal || sel == br_jalr) begin
            exp_result[next_tag] = pc + 32'd4;
        end else begin
            exp_result[next_tag] = expected_alu(op, a, b);
        end
        if (sel != br_none && sel != br_jal) begin
            upd.valid   = 1'b1;
            upd.is_jalr = (sel == br_jalr);
            upd.taken   = taken;
            upd.pc      = pc;
            if (sel == br_jalr) begin
                jump_tgt       = expected_alu(op, a, b) & ~32'h1;
                upd.target     = jump_tgt;
                upd.correct_pc = jump_tgt;
                upd.mispredict = (jump_tgt != ptgt);
            end else begin
                upd.target     = btgt;
                upd.correct_pc = taken ? btgt : pc + 32'd4;
                upd.mispredict = (taken != pt);
            end
            upd_q[lane].push_back(upd);
            // Visible two edges after the issue edge
            due_q[lane].push_back(cycle + 2);
        end
        next_tag = next_tag + 1'b1;
    endtask

    // Waits until every result and credit is back home
    task automatic wait_drain();
        while (outstanding != 0 || ret_q.size() != 0 || due_q[0].size() != 0 ||
               due_q[1].size() != 0 || due_q[2].size() != 0) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    `include "tb_exec_tasks.svh"

    // ========================================================================
    // Monitor, scoreboard and timeout
    // ========================================================================

    // Sampled at the rising edge before the DUT registers update
    always @(posedge clk) begin : monitor
        int                       lane;
        logic [phys_reg_bits-1:0] tag;
        if (cdb_valid === 1'b1) begin
            broadcasts++;
            ret_q.push_back(cycle + 1 + cdb_delay);
            tag = cdb.phys_rd;
            if (!pending[tag]) begin
                errors++;
                $display("Unexpected CDB broadcast in %s for tag %0d", cur_test, tag);
            end else begin
                lane = tag_lane[tag];
                if (order_q[lane][0] != tag) begin
                    errors++;
                    $display("Lane %0d result for tag %0d left out of issue order in %s",
                             lane, tag, cur_test);
                end
                for (int k = 0; k < order_q[lane].size(); k++) begin
                    if (order_q[lane][k] == tag) begin
                        order_q[lane].delete(k);
                        break;
                    end
                end
                if (cdb.result !== exp_result[tag]) begin
                    errors++;
                    $display("Mismatch in %s: tag %0d expected %h actual %h",
                             cur_test, tag, exp_result[tag], cdb.result);
                end
                pending[tag] = 1'b0;
                outstanding--;
            end
        end
        for (int i = 0; i < num_lanes; i++) begin
            // A credit beyond the queue depth means a return without a pop
            if (issue_credit[i] === 1'b1) begin
                if (credits[i] >= lane_queue_depth) begin
                    errors++;
                    $display("Lane %0d returned an issue credit with none outstanding", i);
                end else begin
                    credits[i]++;
                end
            end
            if (due_q[i].size() != 0 && due_q[i][0] == cycle) begin
                if (branch_update[i].valid !== 1'b1) begin
                    errors++;
                    $display("Lane %0d branch update missing in %s", i, cur_test);
                end else if (branch_update[i] !== upd_q[i][0]) begin
                    errors++;
                    $display("Mismatch in %s: lane %0d update expected %h actual %h",
                             cur_test, i, upd_q[i][0], branch_update[i]);
                end
                void'(due_q[i].pop_front());
                void'(upd_q[i].pop_front());
            end else if (rst_n === 1'b1 && branch_update[i].valid !== 1'b0) begin
                errors++;
                $display("Lane %0d branch update raised at the wrong time in %s", i, cur_test);
            end
        end
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_limit);
            $display("Summary: %0d issued, %0d broadcasts, %0d errors",
                     issued, broadcasts, errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // CDB credits go back to the DUT one per cycle at most
    always @(negedge clk) begin
        if (!hold_credits && ret_q.size() != 0 && ret_q[0] <= cycle) begin
            void'(ret_q.pop_front());
            cdb_credit = 1'b1;
        end else begin
            cdb_credit = 1'b0;
        end
    end

    initial begin
        void'($urandom(32'hbcd46135));
        rst_n        = 1'b0;
        issue_valid  = '0;
        issue_req    = '0;
        cdb_credit   = 1'b0;
        hold_credits = 1'b0;
        cdb_delay    = 1;
        errors       = 0;
        issued       = 0;
        broadcasts   = 0;
        outstanding  = 0;
        cycle        = 0;
        next_tag     = '0;
        for (int t = 0; t < 2**phys_reg_bits; t++) begin
            pending[t] = 1'b0;
        end
        for (int i = 0; i < num_lanes; i++) begin
            credits[i] = lane_queue_depth;
        end
        check_reset();
        alu_op_sweep();
        branch_sweep();
        jump_links();
        stall_and_drain();
        $display("Summary: %0d issued, %0d broadcasts, %0d errors",
                 issued, broadcasts, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+testbench
design/exec_pkg.sv
design/alu_shifter.sv
design/branch_resolver.sv
design/execute_lane.sv
design/cdb_arbiter.sv
design/superscalar_execute_stage.sv
testbench/tb_execute_stage.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f src.f --top-module tb_execute_stage \
		-Mdir obj_dir -o tb_execute_stage
	./obj_dir/tb_execute_stage | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
